// File: pad_sys_pkg.sv
// Register port widths and types, pad function encoding
// and the default number of multiplexed pads

package pad_sys_pkg;

  // Register port
  localparam int unsigned REG_DATA_W = 32;
  localparam int unsigned REG_ADDR_W = 8;

  // Word index inside the register space
  localparam int unsigned REG_IDX_W = REG_ADDR_W - 2;

  typedef logic [REG_DATA_W-1:0] reg_data_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // Alternate function select of one pad
  typedef enum logic {
    PAD_FUNC_PERIPH = 1'b0,
    PAD_FUNC_GPIO   = 1'b1
  } pad_func_e;

  // Default number of multiplexed pads
  localparam int unsigned DEFAULT_NUM_MUX_PAD = 14;

endpackage

// File: rst_sync.sv
// Reset synchronizer, asynchronous assert and synchronous release

`timescale 1ns/100ps

module rst_sync (
  input  logic clk_i,
  input  logic rst_n_i,
  output logic rst_sync_n_o
);

  logic [1:0] sync_q;

  // Shift in a one per edge once the external reset is gone
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign rst_sync_n_o = sync_q[1];

  // Release only after the external reset was high for two edges
  a_release_after_rst : assert property (
    @(posedge clk_i) $rose(rst_sync_n_o) |-> rst_n_i && $past(rst_n_i)
  ) else $error("rst_sync: synchronized reset released while rst_n_i low");

endmodule

// File: pad_control.sv
// Pad alternate function registers behind a simple register port
// with word index decode, range check and error response

`timescale 1ns/100ps

module pad_control
  import pad_sys_pkg::*;
#(
  parameter int unsigned NUM_MUX_PAD = DEFAULT_NUM_MUX_PAD
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,

  input  logic                         reg_valid_i,
  input  logic                         reg_write_i,
  input  reg_addr_t                    reg_addr_i,
  input  reg_data_t                    reg_wdata_i,
  output reg_data_t                    reg_rdata_o,
  output logic                         reg_error_o,

  output pad_func_e [NUM_MUX_PAD-1:0]  pad_func_o
);

  // First byte address past the last register
  localparam int unsigned ADDR_LIMIT = NUM_MUX_PAD * 4;

  pad_func_e [NUM_MUX_PAD-1:0] pad_func_q;

  logic [REG_IDX_W-1:0] reg_idx;
  logic                 out_of_range;
  logic                 misaligned;
  logic                 addr_err;
  logic                 wr_en;
  pad_func_e            rd_func;

  // Address decode
  assign reg_idx      = reg_addr_i[REG_ADDR_W-1:2];
  assign out_of_range = 32'(reg_addr_i) >= ADDR_LIMIT;
  assign misaligned   = reg_addr_i[1:0] != 2'b00;
  assign addr_err     = out_of_range | misaligned;

  assign wr_en = reg_valid_i & reg_write_i & ~addr_err;

  // One select register per pad, only bit 0 of the write data is kept
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_MUX_PAD; i++) begin
        pad_func_q[i] <= PAD_FUNC_PERIPH;
      end
    end else if (wr_en) begin
      for (int i = 0; i < NUM_MUX_PAD; i++) begin
        if (reg_idx == REG_IDX_W'(i)) begin
          pad_func_q[i] <= pad_func_e'(reg_wdata_i[0]);
        end
      end
    end
  end

  // Read mux, out of range indices never match
  always_comb begin
    rd_func = PAD_FUNC_PERIPH;
    for (int i = 0; i < NUM_MUX_PAD; i++) begin
      if (reg_idx == REG_IDX_W'(i)) begin
        rd_func = pad_func_q[i];
      end
    end
  end

  // Same cycle response
  always_comb begin
    reg_rdata_o = '0;
    reg_error_o = 1'b0;
    if (reg_valid_i) begin
      if (addr_err) begin
        reg_error_o = 1'b1;
      end else begin
        reg_rdata_o = reg_data_t'(rd_func);
      end
    end
  end

  assign pad_func_o = pad_func_q;

  a_error_needs_valid : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    reg_error_o |-> reg_valid_i
  ) else $error("pad_control: error response without a transfer");

  // A rejected write must not disturb the routing
  a_error_write_no_change : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    reg_valid_i && reg_write_i && reg_error_o |=> $stable(pad_func_o)
  ) else $error("pad_control: rejected write changed a pad function");

endmodule

// File: pad_mux.sv
// Per pad routing between peripheral and GPIO signals,
// the pad input returns only to the owning side

`timescale 1ns/100ps

module pad_mux
  import pad_sys_pkg::*;
#(
  parameter int unsigned NUM_MUX_PAD = DEFAULT_NUM_MUX_PAD
) (
  input  pad_func_e [NUM_MUX_PAD-1:0] pad_func_i,

  // Peripheral side
  input  logic [NUM_MUX_PAD-1:0]      periph_out_i,
  input  logic [NUM_MUX_PAD-1:0]      periph_oe_i,
  output logic [NUM_MUX_PAD-1:0]      periph_in_o,

  // GPIO side
  input  logic [NUM_MUX_PAD-1:0]      gpio_out_i,
  input  logic [NUM_MUX_PAD-1:0]      gpio_oe_i,
  output logic [NUM_MUX_PAD-1:0]      gpio_in_o,

  // Pads
  input  logic [NUM_MUX_PAD-1:0]      pad_in_i,
  output logic [NUM_MUX_PAD-1:0]      pad_out_o,
  output logic [NUM_MUX_PAD-1:0]      pad_oe_o
);

  always_comb begin
    for (int i = 0; i < NUM_MUX_PAD; i++) begin
      // Side without the pad reads zero
      periph_in_o[i] = 1'b0;
      gpio_in_o[i]   = 1'b0;

      unique case (pad_func_i[i])
        PAD_FUNC_GPIO: begin
          pad_out_o[i] = gpio_out_i[i];
          pad_oe_o[i]  = gpio_oe_i[i];
          gpio_in_o[i] = pad_in_i[i];
        end
        default: begin
          pad_out_o[i]   = periph_out_i[i];
          pad_oe_o[i]    = periph_oe_i[i];
          periph_in_o[i] = pad_in_i[i];
        end
      endcase
    end
  end

  // Never return a pad input to both sides
  always_comb begin
    a_single_owner : assert ((periph_in_o & gpio_in_o) == '0)
      else $error("pad_mux: pad input returned to both sides");
  end

endmodule

// File: pad_system.sv
// Pad front end top level, reset synchronizer,
// pad function registers and pad multiplexer

`timescale 1ns/100ps

module pad_system
  import pad_sys_pkg::*;
#(
  parameter int unsigned NUM_MUX_PAD = DEFAULT_NUM_MUX_PAD
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,

  // Register port
  input  logic                    reg_valid_i,
  input  logic                    reg_write_i,
  input  reg_addr_t               reg_addr_i,
  input  reg_data_t               reg_wdata_i,
  output reg_data_t               reg_rdata_o,
  output logic                    reg_error_o,

  // Peripheral and GPIO drives
  input  logic [NUM_MUX_PAD-1:0]  periph_out_i,
  input  logic [NUM_MUX_PAD-1:0]  periph_oe_i,
  input  logic [NUM_MUX_PAD-1:0]  gpio_out_i,
  input  logic [NUM_MUX_PAD-1:0]  gpio_oe_i,

  // Pads
  input  logic [NUM_MUX_PAD-1:0]  pad_in_i,
  output logic [NUM_MUX_PAD-1:0]  pad_out_o,
  output logic [NUM_MUX_PAD-1:0]  pad_oe_o,

  // Returned pad inputs
  output logic [NUM_MUX_PAD-1:0]  periph_in_o,
  output logic [NUM_MUX_PAD-1:0]  gpio_in_o
);

  logic                        rst_sync_n;
  pad_func_e [NUM_MUX_PAD-1:0] pad_func;

  rst_sync u_rst_sync (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .rst_sync_n_o (rst_sync_n)
  );

  pad_control #(
    .NUM_MUX_PAD (NUM_MUX_PAD)
  ) u_pad_control (
    .clk_i       (clk_i),
    .rst_n_i     (rst_sync_n),
    .reg_valid_i (reg_valid_i),
    .reg_write_i (reg_write_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_error_o (reg_error_o),
    .pad_func_o  (pad_func)
  );

  pad_mux #(
    .NUM_MUX_PAD (NUM_MUX_PAD)
  ) u_pad_mux (
    .pad_func_i   (pad_func),
    .periph_out_i (periph_out_i),
    .periph_oe_i  (periph_oe_i),
    .periph_in_o  (periph_in_o),
    .gpio_out_i   (gpio_out_i),
    .gpio_oe_i    (gpio_oe_i),
    .gpio_in_o    (gpio_in_o),
    .pad_in_i     (pad_in_i),
    .pad_out_o    (pad_out_o),
    .pad_oe_o     (pad_oe_o)
  );

endmodule

// File: tb_checks.svh
// Typed compare tasks for register data, single bits and pad vectors,
// with the check counters

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int check_pass = 0;
int check_fail = 0;

task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
  if (got !== exp) begin
    $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    check_fail++;
  end else begin
    check_pass++;
  end
endtask

// Also catches X and Z on the port
task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
    check_fail++;
  end else begin
    check_pass++;
  end
endtask

task automatic check_vec(input string name, input pad_vec_t got, input pad_vec_t exp);
  if (got !== exp) begin
    $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    check_fail++;
  end else begin
    check_pass++;
  end
endtask

`endif

// File: tb_pad_system.sv
// Testbench for the pad front end with clock, reset, random stimulus,
// reference model, per cycle comparison and watchdog

`timescale 1ns/100ps

module tb_pad_system
  import pad_sys_pkg::*;
();

  localparam int NUM_MUX_PAD = int'(DEFAULT_NUM_MUX_PAD);
  localparam int CLK_PERIOD  = 4;
  localparam int RST_CYCLES  = 10;
  localparam int WR_COUNT    = 40;
  localparam int ERR_COUNT   = 24;
  localparam int ROUTE_COUNT = 80;
  localparam int RST_HOLD    = 5;

  // Every test ends with a spare cycle for its report
  localparam int TOTAL_CYCLES = RST_CYCLES + 4 + (NUM_MUX_PAD + 2) + (2 * WR_COUNT + 2)
    + (ERR_COUNT + NUM_MUX_PAD + 2) + (ROUTE_COUNT + 2) + (NUM_MUX_PAD + RST_HOLD + 10);
  localparam int MARGIN_NS = 200;

  typedef logic [NUM_MUX_PAD-1:0] pad_vec_t;

  logic      clk_i;
  logic      rst_n_i;
  logic      reg_valid_i;
  logic      reg_write_i;
  reg_addr_t reg_addr_i;
  reg_data_t reg_wdata_i;
  reg_data_t reg_rdata_o;
  logic      reg_error_o;
  pad_vec_t  periph_out_i;
  pad_vec_t  periph_oe_i;
  pad_vec_t  gpio_out_i;
  pad_vec_t  gpio_oe_i;
  pad_vec_t  pad_in_i;
  pad_vec_t  pad_out_o;
  pad_vec_t  pad_oe_o;
  pad_vec_t  periph_in_o;
  pad_vec_t  gpio_in_o;

  // Set bit marks a GPIO pad in the model
  pad_vec_t    func_m;
  logic [1:0]  sync_m;
  logic [31:0] rand_state = 32'd73505;

  `include "tb_checks.svh"

  pad_system #(
    .NUM_MUX_PAD (NUM_MUX_PAD)
  ) dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state;
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[30:16]) % n;
  endfunction

  // Built from the upper halves only, the low LCG bits repeat with a short period
  function automatic reg_data_t rand_data();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi[31:16], lo[31:16]};
  endfunction

  function automatic pad_vec_t rand_vec();
    return pad_vec_t'(rand_data());
  endfunction

  function automatic reg_addr_t pad_addr(input int pad);
    return reg_addr_t'(pad * 4);
  endfunction

  // Expected pads, returned inputs and register response
  function automatic void ref_model(
    input  pad_vec_t  func,
    input  pad_vec_t  p_out,
    input  pad_vec_t  p_oe,
    input  pad_vec_t  g_out,
    input  pad_vec_t  g_oe,
    input  pad_vec_t  p_in,
    input  logic      valid,
    input  reg_addr_t addr,
    output pad_vec_t  e_out,
    output pad_vec_t  e_oe,
    output pad_vec_t  e_pin,
    output pad_vec_t  e_gin,
    output reg_data_t e_rdata,
    output logic      e_err
  );
    int   idx;
    logic bad;
    e_out   = (func & g_out) | (~func & p_out);
    e_oe    = (func & g_oe) | (~func & p_oe);
    e_pin   = ~func & p_in;
    e_gin   = func & p_in;
    idx     = int'(addr) / 4;
    bad     = (int'(addr) >= NUM_MUX_PAD * 4) || (addr[1:0] != 2'b00);
    e_rdata = '0;
    e_err   = valid & bad;
    if (valid && !bad) begin
      e_rdata = reg_data_t'((func >> idx) & pad_vec_t'(1));
    end
  endfunction

  // Compare at the falling edge and advance the model to the next edge
  always @(negedge clk_i) begin
    pad_vec_t  exp_out;
    pad_vec_t  exp_oe;
    pad_vec_t  exp_pin;
    pad_vec_t  exp_gin;
    reg_data_t exp_rdata;
    logic      exp_err;
    int        widx;
    if (!rst_n_i) begin
      func_m = '0;
      sync_m = 2'b00;
    end
    ref_model(func_m, periph_out_i, periph_oe_i, gpio_out_i, gpio_oe_i, pad_in_i,
              reg_valid_i, reg_addr_i, exp_out, exp_oe, exp_pin, exp_gin, exp_rdata, exp_err);
    check_data("reg_rdata_o", reg_rdata_o, exp_rdata);
    check_bit("reg_error_o", reg_error_o, exp_err);
    check_vec("pad_out_o", pad_out_o, exp_out);
    check_vec("pad_oe_o", pad_oe_o, exp_oe);
    check_vec("periph_in_o", periph_in_o, exp_pin);
    check_vec("gpio_in_o", gpio_in_o, exp_gin);
    if (rst_n_i) begin
      // Writes land only once the synchronized reset is high
      if (sync_m[1] && reg_valid_i && reg_write_i && !exp_err) begin
        widx   = int'(reg_addr_i) / 4;
        func_m = (func_m & ~(pad_vec_t'(1) << widx))
               | (pad_vec_t'(reg_wdata_i[0]) << widx);
      end
      sync_m = {sync_m[0], 1'b1};
    end
  end

  task automatic drive_cycle(input logic valid, input logic write, input reg_addr_t addr,
                             input reg_data_t data);
    @(posedge clk_i);
    reg_valid_i  <= valid;
    reg_write_i  <= write;
    reg_addr_i   <= addr;
    reg_wdata_i  <= data;
    periph_out_i <= rand_vec();
    periph_oe_i  <= rand_vec();
    gpio_out_i   <= rand_vec();
    gpio_oe_i    <= rand_vec();
    pad_in_i     <= rand_vec();
  endtask

  task automatic report_test(input string name, input int fails_before);
    @(negedge clk_i);
    #1;
    if (check_fail == fails_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d mismatches", name, check_fail - fails_before);
    end
  endtask

  initial begin
    int        fails_before;
    int        pad;
    int        pick;
    reg_addr_t bad_addr;
    rst_n_i      <= 1'b0;
    reg_valid_i  <= 1'b0;
    reg_write_i  <= 1'b0;
    reg_addr_i   <= '0;
    reg_wdata_i  <= '0;
    periph_out_i <= '0;
    periph_oe_i  <= '0;
    gpio_out_i   <= '0;
    gpio_oe_i    <= '0;
    pad_in_i     <= '0;
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (3) drive_cycle(1'b0, 1'b0, '0, '0);

    fails_before = check_fail;
    for (int i = 0; i < NUM_MUX_PAD; i++) begin
      drive_cycle(1'b1, 1'b0, pad_addr(i), '0);
    end
    drive_cycle(1'b0, 1'b0, '0, '0);
    report_test("reset values", fails_before);

    // Write then read back the same pad on the next cycle
    fails_before = check_fail;
    for (int i = 0; i < WR_COUNT; i++) begin
      pad = rand_below(NUM_MUX_PAD);
      drive_cycle(1'b1, 1'b1, pad_addr(pad), rand_data());
      drive_cycle(1'b1, 1'b0, pad_addr(pad), '0);
    end
    drive_cycle(1'b0, 1'b0, '0, '0);
    report_test("register write and read", fails_before);

    fails_before = check_fail;
    for (int i = 0; i < ERR_COUNT; i++) begin
      if (i % 2 == 0 && NUM_MUX_PAD < 64) begin
        bad_addr = reg_addr_t'(NUM_MUX_PAD * 4 + rand_below(256 - NUM_MUX_PAD * 4));
      end else begin
        bad_addr = reg_addr_t'(rand_below(NUM_MUX_PAD) * 4 + 1 + rand_below(3));
      end
      drive_cycle(1'b1, i % 3 != 0, bad_addr, ~reg_data_t'(0));
    end
    for (int i = 0; i < NUM_MUX_PAD; i++) begin
      drive_cycle(1'b1, 1'b0, pad_addr(i), '0);
    end
    drive_cycle(1'b0, 1'b0, '0, '0);
    report_test("address errors", fails_before);

    fails_before = check_fail;
    for (int i = 0; i < ROUTE_COUNT; i++) begin
      pick = rand_below(4);
      pad  = rand_below(NUM_MUX_PAD);
      drive_cycle(pick < 2, pick == 0, pad_addr(pad), rand_data());
    end
    drive_cycle(1'b0, 1'b0, '0, '0);
    report_test("random routing", fails_before);

    // Mid-run reset followed by one early and one timely write
    fails_before = check_fail;
    for (int i = 0; i < NUM_MUX_PAD; i++) begin
      drive_cycle(1'b1, 1'b1, pad_addr(i), 32'd1);
    end
    drive_cycle(1'b0, 1'b0, '0, '0);
    rst_n_i <= 1'b0;
    repeat (RST_HOLD) drive_cycle(1'b0, 1'b0, '0, '0);
    rst_n_i <= 1'b1;
    drive_cycle(1'b1, 1'b1, pad_addr(0), 32'd1);
    drive_cycle(1'b0, 1'b0, '0, '0);
    drive_cycle(1'b1, 1'b1, pad_addr(NUM_MUX_PAD - 1), 32'd1);
    drive_cycle(1'b1, 1'b0, pad_addr(0), '0);
    drive_cycle(1'b1, 1'b0, pad_addr(NUM_MUX_PAD - 1), '0);
    drive_cycle(1'b0, 1'b0, '0, '0);
    report_test("reset in mid-run", fails_before);

    $display("checks: %0d passed, %0d failed", check_pass, check_fail);
    if (check_fail == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(TOTAL_CYCLES * CLK_PERIOD + MARGIN_NS);
    $display("Watchdog timeout, the tests did not finish within %0d ns",
             TOTAL_CYCLES * CLK_PERIOD + MARGIN_NS);
    $display("Test failed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+.
pad_sys_pkg.sv
rst_sync.sv
pad_control.sv
pad_mux.sv
pad_system.sv
tb_pad_system.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the pad system testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_pad_system -f verilog.f \
  -o tb_pad_system \
  && ./obj_dir/tb_pad_system | tee sim.log \
  || echo "Verilator build or simulation run error"

grep -q "^Test passed$" sim.log && echo "Simulation PASS" || { echo "Simulation FAIL"; exit 1; }
